/* include/rs_macros.svh */
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// physical register tag, also the width of every broadcast tag
`define RS_PTAG_W 6

`define RS_AREG_W 5  // architectural dest
`define RS_ROB_W  6  // reorder buffer index

// decode info is carried through untouched
`define RS_DEC_W 16

// slots per station
`define RS_ADD_DEPTH 8
`define RS_MUL_DEPTH 4
`define RS_DIV_DEPTH 4

`endif

/* verilog/rs_pkg.sv */
`default_nettype none

`include "rs_macros.svh"

package rs_pkg;

    // station select from dispatch, 2'd3 means no station
    typedef enum logic [1:0] {
        RS_SEL_ADD = 2'd0,
        RS_SEL_MUL = 2'd1,
        RS_SEL_DIV = 2'd2
    } rs_sel_e;

    // one slot, 48 bits
    typedef struct packed {
        logic                  busy;         // slot holds an op
        logic [`RS_PTAG_W-1:0] ps1;
        logic                  ps1_v;        // source 1 available
        logic [`RS_PTAG_W-1:0] ps2;
        logic                  ps2_v;
        logic [`RS_PTAG_W-1:0] pd;
        logic [`RS_AREG_W-1:0] rd;
        logic [`RS_ROB_W-1:0]  rob_entry;
        logic [`RS_DEC_W-1:0]  decode_info;  // opaque to the stations
    } rs_entry_t;

    // tag seen on any of the three result buses, each gated by its own enable
    function automatic logic cdb_hit(
        input logic [`RS_PTAG_W-1:0] tag,
        input logic [`RS_PTAG_W-1:0] tag_add,
        input logic                  we_add,
        input logic [`RS_PTAG_W-1:0] tag_mul,
        input logic                  we_mul,
        input logic [`RS_PTAG_W-1:0] tag_div,
        input logic                  we_div
    );
        return (we_add && (tag_add == tag)) ||
               (we_mul && (tag_mul == tag)) ||
               (we_div && (tag_div == tag));
    endfunction

endpackage

`default_nettype wire

/* verilog/slot_picker.sv */
`default_nettype none

// lowest set bit of req wins
module slot_picker
#(
    parameter int WIDTH = 4
)
(
    input  wire logic [WIDTH-1:0]         req,
    output logic                          found,
    output logic [$clog2(WIDTH)-1:0]      index
);

    localparam int IDX_W = $clog2(WIDTH);

    always_comb
    begin
        found = 1'b0;
        index = '0;
        // walk from the top down, the last hit is the lowest index
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            if (req[i])
            begin
                found = 1'b1;
                index = IDX_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dispatch_router.sv */
`default_nettype none

`include "rs_macros.svh"

module dispatch_router
    import rs_pkg::*;
(
    input  wire logic                  dispatch_valid,
    input  wire rs_sel_e               rs_select,
    input  wire logic [`RS_PTAG_W-1:0] ps1,
    input  wire logic [`RS_PTAG_W-1:0] ps2,
    input  wire logic                  dispatch_ps_ready1,
    input  wire logic                  dispatch_ps_ready2,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_add,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_multiply,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_divide,
    input  wire logic                  regf_we_add,
    input  wire logic                  regf_we_mul,
    input  wire logic                  regf_we_div,
    input  wire logic                  add_full,
    input  wire logic                  multiply_full,
    input  wire logic                  divide_full,
    output logic                       insert_add,
    output logic                       insert_multiply,
    output logic                       insert_divide,
    output logic                       ps1_v_init,
    output logic                       ps2_v_init
);

    logic ps1_bypass;  // ps1 broadcast this cycle
    logic ps2_bypass;

    // same-cycle bypass, a tag on the bus now is ready by the time the slot is written
    assign ps1_bypass = cdb_hit(ps1, cdb_ps_id_add, regf_we_add,
                                cdb_ps_id_multiply, regf_we_mul,
                                cdb_ps_id_divide, regf_we_div);
    assign ps2_bypass = cdb_hit(ps2, cdb_ps_id_add, regf_we_add,
                                cdb_ps_id_multiply, regf_we_mul,
                                cdb_ps_id_divide, regf_we_div);

    assign ps1_v_init = dispatch_ps_ready1 || ps1_bypass;
    assign ps2_v_init = dispatch_ps_ready2 || ps2_bypass;

    // one strobe at most, dropped when the target is full
    always_comb
    begin
        insert_add      = 1'b0;
        insert_multiply = 1'b0;
        insert_divide   = 1'b0;
        if (dispatch_valid)
        begin
            case (rs_select)
                RS_SEL_ADD: insert_add      = !add_full;
                RS_SEL_MUL: insert_multiply = !multiply_full;
                RS_SEL_DIV: insert_divide   = !divide_full;
                default:
                begin
                    insert_add = 1'b0;  // select 3, nothing to do
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rs_station.sv */
`default_nettype none

`include "rs_macros.svh"

module rs_station
    import rs_pkg::*;
#(
    parameter int DEPTH = 4  // 2 or more
)
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  insert,          // already checked against full
    input  wire logic [`RS_PTAG_W-1:0] ps1,
    input  wire logic [`RS_PTAG_W-1:0] ps2,
    input  wire logic                  ps1_v_init,
    input  wire logic                  ps2_v_init,
    input  wire logic [`RS_PTAG_W-1:0] pd,
    input  wire logic [`RS_AREG_W-1:0] rd,
    input  wire logic [`RS_ROB_W-1:0]  rob_entry,
    input  wire logic [`RS_DEC_W-1:0]  decode_info_in,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_add,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_multiply,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_divide,
    input  wire logic                  regf_we_add,
    input  wire logic                  regf_we_mul,
    input  wire logic                  regf_we_div,
    input  wire logic                  fu_busy,
    output logic                       fu_ready,
    output logic [`RS_PTAG_W-1:0]      iss_ps1,
    output logic [`RS_PTAG_W-1:0]      iss_ps2,
    output logic [`RS_PTAG_W-1:0]      iss_pd,
    output logic [`RS_AREG_W-1:0]      iss_rd,
    output logic [`RS_ROB_W-1:0]       iss_rob_entry,
    output logic [`RS_DEC_W-1:0]       iss_decode_info,
    output logic                       full
);

    localparam int IDX_W = $clog2(DEPTH);

    rs_entry_t        slot_q [DEPTH];  // station storage
    rs_entry_t        new_entry;       // op being written on insert
    rs_entry_t        iss_entry;       // slot picked for issue

    logic [DEPTH-1:0] free_vec;
    logic [DEPTH-1:0] ready_vec;       // busy with both sources available
    logic             free_found;
    logic             ready_found;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] ready_idx;
    logic             issue;

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            free_vec[i]  = !slot_q[i].busy;
            ready_vec[i] = slot_q[i].busy && slot_q[i].ps1_v && slot_q[i].ps2_v;
        end
    end

    // where a new op goes
    slot_picker #(
        .WIDTH (DEPTH)
    ) u_free_pick (
        .req   (free_vec),
        .found (free_found),
        .index (free_idx)
    );

    // oldest-slot-first is not implied, just lowest index
    slot_picker #(
        .WIDTH (DEPTH)
    ) u_issue_pick (
        .req   (ready_vec),
        .found (ready_found),
        .index (ready_idx)
    );

    assign full  = !free_found;
    assign issue = ready_found && !fu_busy;  // fu takes it at the next edge

    always_comb
    begin
        new_entry.busy        = 1'b1;
        new_entry.ps1         = ps1;
        new_entry.ps1_v       = ps1_v_init;  // bypass folded in by the router
        new_entry.ps2         = ps2;
        new_entry.ps2_v       = ps2_v_init;
        new_entry.pd          = pd;
        new_entry.rd          = rd;
        new_entry.rob_entry   = rob_entry;
        new_entry.decode_info = decode_info_in;
    end

    assign iss_entry = slot_q[ready_idx];

    // issue port reads zero when idle
    assign fu_ready        = issue;
    assign iss_ps1         = issue ? iss_entry.ps1 : '0;
    assign iss_ps2         = issue ? iss_entry.ps2 : '0;
    assign iss_pd          = issue ? iss_entry.pd : '0;
    assign iss_rd          = issue ? iss_entry.rd : '0;
    assign iss_rob_entry   = issue ? iss_entry.rob_entry : '0;
    assign iss_decode_info = issue ? iss_entry.decode_info : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                slot_q[i].busy <= 1'b0;  // payload left as is
            end
        end
        else
        begin
            // wakeup, also on free slots, harmless
            for (int i = 0; i < DEPTH; i++)
            begin
                if (cdb_hit(slot_q[i].ps1, cdb_ps_id_add, regf_we_add,
                            cdb_ps_id_multiply, regf_we_mul,
                            cdb_ps_id_divide, regf_we_div))
                begin
                    slot_q[i].ps1_v <= 1'b1;
                end
                if (cdb_hit(slot_q[i].ps2, cdb_ps_id_add, regf_we_add,
                            cdb_ps_id_multiply, regf_we_mul,
                            cdb_ps_id_divide, regf_we_div))
                begin
                    slot_q[i].ps2_v <= 1'b1;
                end
            end
            if (issue)
            begin
                slot_q[ready_idx].busy <= 1'b0;  // freed at the issue edge
            end
            // insert slot is free, never the issuing one
            if (insert)
            begin
                slot_q[free_idx] <= new_entry;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rs_top.sv */
`default_nettype none

`include "rs_macros.svh"

module rs_top
    import rs_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    // dispatch, no ready back, core watches the full flags
    input  wire logic                  dispatch_valid,
    input  wire rs_sel_e               rs_select,
    input  wire logic [`RS_PTAG_W-1:0] ps1,
    input  wire logic [`RS_PTAG_W-1:0] ps2,
    input  wire logic                  dispatch_ps_ready1,
    input  wire logic                  dispatch_ps_ready2,
    input  wire logic [`RS_PTAG_W-1:0] pd,
    input  wire logic [`RS_AREG_W-1:0] rd,
    input  wire logic [`RS_ROB_W-1:0]  rob_entry,
    input  wire logic [`RS_DEC_W-1:0]  decode_info_in,
    // result broadcast
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_add,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_multiply,
    input  wire logic [`RS_PTAG_W-1:0] cdb_ps_id_divide,
    input  wire logic                  regf_we_add,
    input  wire logic                  regf_we_mul,
    input  wire logic                  regf_we_div,
    input  wire logic                  add_fu_busy,
    input  wire logic                  multiply_fu_busy,
    input  wire logic                  divide_fu_busy,
    output logic                       add_fu_ready,
    output logic [`RS_PTAG_W-1:0]      add_ps1,
    output logic [`RS_PTAG_W-1:0]      add_ps2,
    output logic [`RS_PTAG_W-1:0]      add_pd,
    output logic [`RS_AREG_W-1:0]      add_rd,
    output logic [`RS_ROB_W-1:0]       add_rob_entry,
    output logic [`RS_DEC_W-1:0]       add_decode_info_out,
    output logic                       add_full,
    output logic                       multiply_fu_ready,
    output logic [`RS_PTAG_W-1:0]      multiply_ps1,
    output logic [`RS_PTAG_W-1:0]      multiply_ps2,
    output logic [`RS_PTAG_W-1:0]      multiply_pd,
    output logic [`RS_AREG_W-1:0]      multiply_rd,
    output logic [`RS_ROB_W-1:0]       multiply_rob_entry,
    output logic [`RS_DEC_W-1:0]       multiply_decode_info_out,
    output logic                       multiply_full,
    output logic                       divide_fu_ready,
    output logic [`RS_PTAG_W-1:0]      divide_ps1,
    output logic [`RS_PTAG_W-1:0]      divide_ps2,
    output logic [`RS_PTAG_W-1:0]      divide_pd,
    output logic [`RS_AREG_W-1:0]      divide_rd,
    output logic [`RS_ROB_W-1:0]       divide_rob_entry,
    output logic [`RS_DEC_W-1:0]       divide_decode_info_out,
    output logic                       divide_full
);

    logic insert_add;       // router strobes, full already checked
    logic insert_multiply;
    logic insert_divide;
    logic ps1_v_init;       // shared by all stations
    logic ps2_v_init;

    dispatch_router u_router (
        .dispatch_valid     (dispatch_valid),
        .rs_select          (rs_select),
        .ps1                (ps1),
        .ps2                (ps2),
        .dispatch_ps_ready1 (dispatch_ps_ready1),
        .dispatch_ps_ready2 (dispatch_ps_ready2),
        .cdb_ps_id_add      (cdb_ps_id_add),
        .cdb_ps_id_multiply (cdb_ps_id_multiply),
        .cdb_ps_id_divide   (cdb_ps_id_divide),
        .regf_we_add        (regf_we_add),
        .regf_we_mul        (regf_we_mul),
        .regf_we_div        (regf_we_div),
        .add_full           (add_full),
        .multiply_full      (multiply_full),
        .divide_full        (divide_full),
        .insert_add         (insert_add),
        .insert_multiply    (insert_multiply),
        .insert_divide      (insert_divide),
        .ps1_v_init         (ps1_v_init),
        .ps2_v_init         (ps2_v_init)
    );

    rs_station #(
        .DEPTH (`RS_ADD_DEPTH)
    ) u_add_rs (
        .clk                (clk),
        .rst                (rst),
        .insert             (insert_add),
        .ps1                (ps1),
        .ps2                (ps2),
        .ps1_v_init         (ps1_v_init),
        .ps2_v_init         (ps2_v_init),
        .pd                 (pd),
        .rd                 (rd),
        .rob_entry          (rob_entry),
        .decode_info_in     (decode_info_in),
        .cdb_ps_id_add      (cdb_ps_id_add),
        .cdb_ps_id_multiply (cdb_ps_id_multiply),
        .cdb_ps_id_divide   (cdb_ps_id_divide),
        .regf_we_add        (regf_we_add),
        .regf_we_mul        (regf_we_mul),
        .regf_we_div        (regf_we_div),
        .fu_busy            (add_fu_busy),
        .fu_ready           (add_fu_ready),
        .iss_ps1            (add_ps1),
        .iss_ps2            (add_ps2),
        .iss_pd             (add_pd),
        .iss_rd             (add_rd),
        .iss_rob_entry      (add_rob_entry),
        .iss_decode_info    (add_decode_info_out),
        .full               (add_full)
    );

    rs_station #(
        .DEPTH (`RS_MUL_DEPTH)
    ) u_mul_rs (
        .clk                (clk),
        .rst                (rst),
        .insert             (insert_multiply),
        .ps1                (ps1),
        .ps2                (ps2),
        .ps1_v_init         (ps1_v_init),
        .ps2_v_init         (ps2_v_init),
        .pd                 (pd),
        .rd                 (rd),
        .rob_entry          (rob_entry),
        .decode_info_in     (decode_info_in),
        .cdb_ps_id_add      (cdb_ps_id_add),
        .cdb_ps_id_multiply (cdb_ps_id_multiply),
        .cdb_ps_id_divide   (cdb_ps_id_divide),
        .regf_we_add        (regf_we_add),
        .regf_we_mul        (regf_we_mul),
        .regf_we_div        (regf_we_div),
        .fu_busy            (multiply_fu_busy),
        .fu_ready           (multiply_fu_ready),
        .iss_ps1            (multiply_ps1),
        .iss_ps2            (multiply_ps2),
        .iss_pd             (multiply_pd),
        .iss_rd             (multiply_rd),
        .iss_rob_entry      (multiply_rob_entry),
        .iss_decode_info    (multiply_decode_info_out),
        .full               (multiply_full)
    );

    rs_station #(
        .DEPTH (`RS_DIV_DEPTH)
    ) u_div_rs (
        .clk                (clk),
        .rst                (rst),
        .insert             (insert_divide),
        .ps1                (ps1),
        .ps2                (ps2),
        .ps1_v_init         (ps1_v_init),
        .ps2_v_init         (ps2_v_init),
        .pd                 (pd),
        .rd                 (rd),
        .rob_entry          (rob_entry),
        .decode_info_in     (decode_info_in),
        .cdb_ps_id_add      (cdb_ps_id_add),
        .cdb_ps_id_multiply (cdb_ps_id_multiply),
        .cdb_ps_id_divide   (cdb_ps_id_divide),
        .regf_we_add        (regf_we_add),
        .regf_we_mul        (regf_we_mul),
        .regf_we_div        (regf_we_div),
        .fu_busy            (divide_fu_busy),
        .fu_ready           (divide_fu_ready),
        .iss_ps1            (divide_ps1),
        .iss_ps2            (divide_ps2),
        .iss_pd             (divide_pd),
        .iss_rd             (divide_rd),
        .iss_rob_entry      (divide_rob_entry),
        .iss_decode_info    (divide_decode_info_out),
        .full               (divide_full)
    );

endmodule

`default_nettype wire

/* verification/rs_chk.sv */
`default_nettype none

// issue-port rules, sampled at the rising edge
module rs_chk
(
    input wire logic clk,
    input wire logic rst,
    input wire logic add_fu_busy,
    input wire logic multiply_fu_busy,
    input wire logic divide_fu_busy,
    input wire logic add_fu_ready,
    input wire logic multiply_fu_ready,
    input wire logic divide_fu_ready,
    input wire logic add_full,
    input wire logic multiply_full,
    input wire logic divide_full
);

    // ready is already masked by busy
    a_ready_busy: assert property (@(posedge clk) disable iff (rst)
        !(add_fu_ready && add_fu_busy) &&
        !(multiply_fu_ready && multiply_fu_busy) &&
        !(divide_fu_ready && divide_fu_busy))
    else $error("fu_ready high while its unit is busy");

    a_ready_after_rst: assert property (@(posedge clk)
        rst |=> !(add_fu_ready || multiply_fu_ready || divide_fu_ready))
    else $error("fu_ready high right after reset");

    a_full_after_rst: assert property (@(posedge clk)
        rst |=> !(add_full || multiply_full || divide_full))
    else $error("full flag high right after reset");

endmodule

bind rs_top rs_chk u_chk (.*);

`default_nettype wire

/* verification/rs_tb.sv */
`default_nettype none

`include "rs_macros.svh"

module rs_tb
    import rs_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  dispatch_valid;
    rs_sel_e               rs_select;
    logic [`RS_PTAG_W-1:0] ps1;
    logic [`RS_PTAG_W-1:0] ps2;
    logic                  dispatch_ps_ready1;
    logic                  dispatch_ps_ready2;
    logic [`RS_PTAG_W-1:0] pd;
    logic [`RS_AREG_W-1:0] rd;
    logic [`RS_ROB_W-1:0]  rob_entry;
    logic [`RS_DEC_W-1:0]  decode_info_in;
    logic [`RS_PTAG_W-1:0] cdb_ps_id_add;
    logic [`RS_PTAG_W-1:0] cdb_ps_id_multiply;
    logic [`RS_PTAG_W-1:0] cdb_ps_id_divide;
    logic                  regf_we_add;
    logic                  regf_we_mul;
    logic                  regf_we_div;
    logic                  add_fu_busy;
    logic                  multiply_fu_busy;
    logic                  divide_fu_busy;
    logic                  add_fu_ready;
    logic [`RS_PTAG_W-1:0] add_ps1;
    logic [`RS_PTAG_W-1:0] add_ps2;
    logic [`RS_PTAG_W-1:0] add_pd;
    logic [`RS_AREG_W-1:0] add_rd;
    logic [`RS_ROB_W-1:0]  add_rob_entry;
    logic [`RS_DEC_W-1:0]  add_decode_info_out;
    logic                  add_full;
    logic                  multiply_fu_ready;
    logic [`RS_PTAG_W-1:0] multiply_ps1;
    logic [`RS_PTAG_W-1:0] multiply_ps2;
    logic [`RS_PTAG_W-1:0] multiply_pd;
    logic [`RS_AREG_W-1:0] multiply_rd;
    logic [`RS_ROB_W-1:0]  multiply_rob_entry;
    logic [`RS_DEC_W-1:0]  multiply_decode_info_out;
    logic                  multiply_full;
    logic                  divide_fu_ready;
    logic [`RS_PTAG_W-1:0] divide_ps1;
    logic [`RS_PTAG_W-1:0] divide_ps2;
    logic [`RS_PTAG_W-1:0] divide_pd;
    logic [`RS_AREG_W-1:0] divide_rd;
    logic [`RS_ROB_W-1:0]  divide_rob_entry;
    logic [`RS_DEC_W-1:0]  divide_decode_info_out;
    logic                  divide_full;

    rs_entry_t   mdl [3][8];    // model slots, class 0 add, 1 mul, 2 div
    logic        iss_seen [3];  // DUT issued in the last checked cycle
    logic        full_seen [3];
    rs_entry_t   iss_got [3];
    logic [63:0] outstanding;   // dispatched and not yet issued, by rob
    logic [31:0] lcg_state;

    rs_top u_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic int class_depth(input int c);
        return (c == 0) ? `RS_ADD_DEPTH : ((c == 1) ? `RS_MUL_DEPTH : `RS_DIV_DEPTH);
    endfunction

    function automatic logic busy_of(input int c);
        return (c == 0) ? add_fu_busy : ((c == 1) ? multiply_fu_busy : divide_fu_busy);
    endfunction

    // tag counts only while its bus enable is high
    function automatic logic broadcast_hit(input logic [`RS_PTAG_W-1:0] tag);
        return (regf_we_add && cdb_ps_id_add == tag) ||
               (regf_we_mul && cdb_ps_id_multiply == tag) ||
               (regf_we_div && cdb_ps_id_divide == tag);
    endfunction

    function automatic int lowest_free(input int c);
        int r;
        r = -1;
        for (int i = class_depth(c) - 1; i >= 0; i--)
            if (!mdl[c][i].busy)
                r = i;
        return r;
    endfunction

    function automatic int lowest_ready(input int c);
        int r;
        r = -1;
        for (int i = class_depth(c) - 1; i >= 0; i--)
            if (mdl[c][i].busy && mdl[c][i].ps1_v && mdl[c][i].ps2_v)
                r = i;
        return r;
    endfunction

    function automatic logic [14:0] rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:16];
    endfunction

    task automatic fail_now(input string msg);
        $display("%0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_val(input logic [47:0] got, input logic [47:0] exp,
                             input string what);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // issue port of one class, packed into a slot layout
    task automatic read_port(input int c, output logic rdy, output logic full,
                             output rs_entry_t e);
        e = '0;
        case (c)
            0:
            begin
                rdy           = add_fu_ready;
                full          = add_full;
                e.ps1         = add_ps1;
                e.ps2         = add_ps2;
                e.pd          = add_pd;
                e.rd          = add_rd;
                e.rob_entry   = add_rob_entry;
                e.decode_info = add_decode_info_out;
            end
            1:
            begin
                rdy           = multiply_fu_ready;
                full          = multiply_full;
                e.ps1         = multiply_ps1;
                e.ps2         = multiply_ps2;
                e.pd          = multiply_pd;
                e.rd          = multiply_rd;
                e.rob_entry   = multiply_rob_entry;
                e.decode_info = multiply_decode_info_out;
            end
            default:
            begin
                rdy           = divide_fu_ready;
                full          = divide_full;
                e.ps1         = divide_ps1;
                e.ps2         = divide_ps2;
                e.pd          = divide_pd;
                e.rd          = divide_rd;
                e.rob_entry   = divide_rob_entry;
                e.decode_info = divide_decode_info_out;
            end
        endcase
    endtask

    task automatic drive_dispatch(input int sel, input logic [`RS_PTAG_W-1:0] t1,
                                  input logic r1, input logic [`RS_PTAG_W-1:0] t2,
                                  input logic r2, input logic [`RS_ROB_W-1:0] rob);
        dispatch_valid     = 1'b1;
        rs_select          = rs_sel_e'(sel);
        ps1                = t1;
        dispatch_ps_ready1 = r1;
        ps2                = t2;
        dispatch_ps_ready2 = r2;
        pd                 = ~rob;         // fields derived from rob, all distinct
        rd                 = rob[4:0] ^ 5'h15;
        rob_entry          = rob;
        decode_info_in     = {4'h5, rob, ~rob};
    endtask

    task automatic drive_bcast(input int b, input logic [`RS_PTAG_W-1:0] tag, input logic we);
        case (b)
            0:
            begin
                cdb_ps_id_add = tag;
                regf_we_add   = we;
            end
            1:
            begin
                cdb_ps_id_multiply = tag;
                regf_we_mul        = we;
            end
            default:
            begin
                cdb_ps_id_divide = tag;
                regf_we_div      = we;
            end
        endcase
    endtask

    // check all issue ports against the model, step the model, cross the edge
    task automatic run_cycle();
        int        pick;
        int        fr;
        logic      go;
        logic      rdy;
        logic      full;
        rs_entry_t got;
        rs_entry_t exp;
        #3;  // inputs driven at +2, now settled
        for (int c = 0; c < 3; c++)
        begin
            pick = lowest_ready(c);
            fr   = lowest_free(c);
            go   = (pick >= 0) && !busy_of(c);
            read_port(c, rdy, full, got);
            exp = '0;
            if (go)
                exp = mdl[c][pick];
            exp.busy  = 1'b0;  // not on the port
            exp.ps1_v = 1'b0;
            exp.ps2_v = 1'b0;
            check_val(rdy, go, $sformatf("class %0d fu_ready", c));
            check_val(full, fr < 0, $sformatf("class %0d full", c));
            check_val(got, exp, $sformatf("class %0d issue fields", c));
            iss_seen[c]  = rdy;
            full_seen[c] = full;
            iss_got[c]   = got;
            // wakeup of stored sources
            for (int i = 0; i < class_depth(c); i++)
            begin
                if (broadcast_hit(mdl[c][i].ps1))
                    mdl[c][i].ps1_v = 1'b1;
                if (broadcast_hit(mdl[c][i].ps2))
                    mdl[c][i].ps2_v = 1'b1;
            end
            if (go)
                mdl[c][pick].busy = 1'b0;
            // insert into the slot that was free before the edge, dropped when full
            if (dispatch_valid && int'(rs_select) == c && fr >= 0)
            begin
                mdl[c][fr].busy        = 1'b1;
                mdl[c][fr].ps1         = ps1;
                mdl[c][fr].ps1_v       = dispatch_ps_ready1 || broadcast_hit(ps1);
                mdl[c][fr].ps2         = ps2;
                mdl[c][fr].ps2_v       = dispatch_ps_ready2 || broadcast_hit(ps2);
                mdl[c][fr].pd          = pd;
                mdl[c][fr].rd          = rd;
                mdl[c][fr].rob_entry   = rob_entry;
                mdl[c][fr].decode_info = decode_info_in;
            end
        end
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;  // pulses last one cycle, busy persists
        regf_we_add    = 1'b0;
        regf_we_mul    = 1'b0;
        regf_we_div    = 1'b0;
    endtask

    task automatic test_reset();
        run_cycle();
        for (int c = 0; c < 3; c++)
        begin
            check_val(iss_seen[c], 1'b0, $sformatf("class %0d fu_ready after reset", c));
            check_val(full_seen[c], 1'b0, $sformatf("class %0d full after reset", c));
        end
    endtask

    task automatic test_ready_issue();
        logic [`RS_ROB_W-1:0] rob;
        for (int c = 0; c < 3; c++)
        begin
            rob = 6'(c + 1);
            drive_dispatch(c, 6'(c + 4), 1'b1, 6'(c + 8), 1'b1, rob);
            run_cycle();  // dispatch edge
            run_cycle();  // issue cycle
            for (int k = 0; k < 3; k++)
                check_val(iss_seen[k], k == c, $sformatf("class %0d issue after dispatch", k));
            check_val(iss_got[c].rob_entry, rob, "issued rob");
            check_val(iss_got[c].pd, 6'(~rob), "issued pd");
            check_val(iss_got[c].ps2, 6'(c + 8), "issued ps2");
        end
    endtask

    task automatic test_wakeup();
        int                    s;
        logic [`RS_PTAG_W-1:0] tag;
        for (int b = 0; b < 3; b++)
        begin
            s   = (b + 1) % 3;
            tag = 6'(6'h30 + b);
            drive_dispatch(s, tag, 1'b0, 6'h01, 1'b1, 6'(20 + b));
            run_cycle();
            drive_bcast(b, tag, 1'b0);  // tag without enable, ignored
            run_cycle();
            run_cycle();
            check_val(iss_seen[s], 1'b0, "issue with unready source");
            drive_bcast(b, tag, 1'b1);
            run_cycle();
            check_val(iss_seen[s], 1'b0, "issue in broadcast cycle");
            run_cycle();
            check_val(iss_seen[s], 1'b1, "issue after wakeup");
            check_val(iss_got[s].rob_entry, 6'(20 + b), "woken rob");
            // bypass, tag on the bus during dispatch
            drive_dispatch(s, 6'(tag + 8), 1'b0, 6'h02, 1'b1, 6'(24 + b));
            drive_bcast(b, 6'(tag + 8), 1'b1);
            run_cycle();
            run_cycle();
            check_val(iss_seen[s], 1'b1, "issue after bypass");
            check_val(iss_got[s].rob_entry, 6'(24 + b), "bypass rob");
        end
    endtask

    task automatic test_backpressure();
        multiply_fu_busy = 1'b1;
        for (int k = 0; k < 4; k++)
        begin
            drive_dispatch(1, 6'h03, 1'b1, 6'h04, 1'b1, 6'(10 + k));
            run_cycle();
        end
        run_cycle();
        check_val(full_seen[1], 1'b1, "multiply_full with four stored");
        drive_dispatch(1, 6'h03, 1'b1, 6'h04, 1'b1, 6'd14);  // dropped
        run_cycle();
        multiply_fu_busy = 1'b0;
        for (int k = 0; k < 4; k++)
        begin
            run_cycle();
            check_val(iss_seen[1], 1'b1, "issue after busy release");
            check_val(iss_got[1].rob_entry, 6'(10 + k), "release order");
        end
        run_cycle();
        run_cycle();
        check_val(iss_seen[1], 1'b0, "dropped op issued");
    endtask

    task automatic retire_issues();
        for (int c = 0; c < 3; c++)
        begin
            if (iss_seen[c])
            begin
                assert (outstanding[iss_got[c].rob_entry])
                else fail_now($sformatf("rob %0d issued without a pending dispatch",
                                        iss_got[c].rob_entry));
                outstanding[iss_got[c].rob_entry] = 1'b0;
            end
        end
    endtask

    task automatic test_random_mix();
        int                   sel;
        logic [`RS_ROB_W-1:0] next_rob;
        next_rob = 6'd32;
        for (int n = 0; n < 200; n++)
        begin
            add_fu_busy      = (rand_next() % 4 == 0);
            multiply_fu_busy = (rand_next() % 4 == 0);
            divide_fu_busy   = (rand_next() % 4 == 0);
            sel = int'(rand_next() % 4);  // 3 selects no station
            if (rand_next() % 2 == 0 && !outstanding[next_rob] &&
                (sel == 3 || lowest_free(sel) >= 0))
            begin
                drive_dispatch(sel, 6'(rand_next() % 16), 1'(rand_next() % 2),
                               6'(rand_next() % 16), 1'(rand_next() % 2), next_rob);
                if (sel < 3)
                    outstanding[next_rob] = 1'b1;
                next_rob++;
            end
            for (int b = 0; b < 3; b++)
                drive_bcast(b, 6'(rand_next() % 16), rand_next() % 3 == 0);
            run_cycle();
            retire_issues();
        end
        add_fu_busy      = 1'b0;
        multiply_fu_busy = 1'b0;
        divide_fu_busy   = 1'b0;
        // drain, sweep all low tags over the buses
        for (int k = 0; k < 100 && outstanding != '0; k++)
        begin
            for (int b = 0; b < 3; b++)
                drive_bcast(b, 6'((3 * k + b) % 16), 1'b1);
            run_cycle();
            retire_issues();
        end
        if (outstanding != '0)
            fail_now("timeout: dispatched operations never issued during drain");
    endtask

    initial
    begin
        lcg_state          = 32'd56908;
        outstanding        = '0;
        rst                = 1'b1;
        dispatch_valid     = 1'b0;
        rs_select          = RS_SEL_ADD;
        ps1                = '0;
        ps2                = '0;
        dispatch_ps_ready1 = 1'b0;
        dispatch_ps_ready2 = 1'b0;
        pd                 = '0;
        rd                 = '0;
        rob_entry          = '0;
        decode_info_in     = '0;
        cdb_ps_id_add      = '0;
        cdb_ps_id_multiply = '0;
        cdb_ps_id_divide   = '0;
        regf_we_add        = 1'b0;
        regf_we_mul        = 1'b0;
        regf_we_div        = 1'b0;
        add_fu_busy        = 1'b0;
        multiply_fu_busy   = 1'b0;
        divide_fu_busy     = 1'b0;
        for (int c = 0; c < 3; c++)
            for (int i = 0; i < 8; i++)
                mdl[c][i] = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_ready_issue();
        test_wakeup();
        test_backpressure();
        test_random_mix();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
verilog/rs_pkg.sv
verilog/slot_picker.sv
verilog/dispatch_router.sv
verilog/rs_station.sv
verilog/rs_top.sv
verification/rs_chk.sv
verification/rs_tb.sv
